// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // Datapath widths
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int opcode_w   = 7;
    localparam int funct3_w   = 3;
    localparam int funct7_w   = 7;

    // Instruction field positions
    localparam int opcode_lsb = 0;
    localparam int rd_lsb     = 7;
    localparam int funct3_lsb = 12;
    localparam int rs1_lsb    = 15;
    localparam int rs2_lsb    = 20;
    localparam int funct7_lsb = 25;

    // Function codes used by the supported subset
    localparam logic [funct3_w-1:0] f3_add_sub = 3'b000;
    localparam logic [funct3_w-1:0] f3_or      = 3'b110;
    localparam logic [funct3_w-1:0] f3_and     = 3'b111;
    localparam logic [funct3_w-1:0] f3_beq     = 3'b000;
    localparam logic [funct7_w-1:0] f7_sub     = 7'b0100000;

    // ADDI x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

    typedef enum logic [opcode_w-1:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111
    } opcode_e;

    typedef enum logic [1:0] {
        alu_add = 2'd0,
        alu_sub = 2'd1,
        alu_and = 2'd2,
        alu_or  = 2'd3
    } alu_op_e;

    // Write-back source
    typedef enum logic [1:0] {
        wb_alu   = 2'd0,
        wb_mem   = 2'd1,
        wb_pc4   = 2'd2,
        wb_pcimm = 2'd3
    } wb_sel_e;

    // Next-PC kind
    typedef enum logic [1:0] {
        pc_seq  = 2'd0,
        pc_beq  = 2'd1,
        pc_jal  = 2'd2,
        pc_jalr = 2'd3
    } pc_sel_e;

endpackage

`default_nettype wire

// File: hdl/ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ctrl_if;

    cpu_pkg::alu_op_e alu_op;
    cpu_pkg::wb_sel_e wb_sel;
    cpu_pkg::pc_sel_e pc_sel;
    logic             src0_zero;
    logic             src1_imm;
    logic             reg_we;
    logic             mem_we;

    modport decoder (
        output alu_op, wb_sel, pc_sel, src0_zero, src1_imm, reg_we, mem_we
    );

    modport datapath (
        input alu_op, wb_sel, pc_sel, src0_zero, src1_imm, reg_we, mem_we
    );

endinterface

`default_nettype wire

// File: hdl/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit (
    input  logic [cpu_pkg::xlen-1:0] instr,
    ctrl_if.decoder                  ctrl
);

    cpu_pkg::opcode_e                opcode;
    logic [cpu_pkg::funct3_w-1:0]    funct3;
    logic [cpu_pkg::funct7_w-1:0]    funct7;
    cpu_pkg::alu_op_e                op_alu;
    logic                            op_ok;

    assign opcode = cpu_pkg::opcode_e'(instr[cpu_pkg::opcode_lsb +: cpu_pkg::opcode_w]);
    assign funct3 = instr[cpu_pkg::funct3_lsb +: cpu_pkg::funct3_w];
    assign funct7 = instr[cpu_pkg::funct7_lsb +: cpu_pkg::funct7_w];

    // ALU operation for OP and OP_IMM
    always_comb begin
        op_alu = cpu_pkg::alu_add;
        op_ok  = 1'b1;
        case (funct3)
            cpu_pkg::f3_add_sub: begin
                op_alu = (funct7 == cpu_pkg::f7_sub) ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            end
            cpu_pkg::f3_or:  op_alu = cpu_pkg::alu_or;
            cpu_pkg::f3_and: op_alu = cpu_pkg::alu_and;
            // Shifts and compares are outside the subset
            default:         op_ok  = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Main decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        // Defaults form a no-operation
        ctrl.alu_op    = cpu_pkg::alu_add;
        ctrl.wb_sel    = cpu_pkg::wb_alu;
        ctrl.pc_sel    = cpu_pkg::pc_seq;
        ctrl.src0_zero = 1'b0;
        ctrl.src1_imm  = 1'b0;
        ctrl.reg_we    = 1'b0;
        ctrl.mem_we    = 1'b0;
        case (opcode)
            cpu_pkg::opc_op: begin
                ctrl.alu_op = op_alu;
                ctrl.reg_we = op_ok;
            end
            cpu_pkg::opc_op_imm: begin
                // funct7 bits are immediate here, so no SUB
                ctrl.alu_op   = (funct3 == cpu_pkg::f3_add_sub) ? cpu_pkg::alu_add : op_alu;
                ctrl.src1_imm = 1'b1;
                ctrl.reg_we   = op_ok;
            end
            cpu_pkg::opc_load: begin
                ctrl.src1_imm = 1'b1;
                ctrl.wb_sel   = cpu_pkg::wb_mem;
                ctrl.reg_we   = 1'b1;
            end
            cpu_pkg::opc_store: begin
                ctrl.src1_imm = 1'b1;
                ctrl.mem_we   = 1'b1;
            end
            cpu_pkg::opc_branch: begin
                if (funct3 == cpu_pkg::f3_beq) begin
                    ctrl.alu_op = cpu_pkg::alu_sub;
                    ctrl.pc_sel = cpu_pkg::pc_beq;
                end
            end
            cpu_pkg::opc_jal: begin
                ctrl.pc_sel = cpu_pkg::pc_jal;
                ctrl.wb_sel = cpu_pkg::wb_pc4;
                ctrl.reg_we = 1'b1;
            end
            cpu_pkg::opc_jalr: begin
                ctrl.src1_imm = 1'b1;
                ctrl.pc_sel   = cpu_pkg::pc_jalr;
                ctrl.wb_sel   = cpu_pkg::wb_pc4;
                ctrl.reg_we   = 1'b1;
            end
            cpu_pkg::opc_lui: begin
                // 0 + imm through the ALU
                ctrl.src0_zero = 1'b1;
                ctrl.src1_imm  = 1'b1;
                ctrl.reg_we    = 1'b1;
            end
            cpu_pkg::opc_auipc: begin
                ctrl.wb_sel = cpu_pkg::wb_pcimm;
                ctrl.reg_we = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [cpu_pkg::xlen-1:0] instr,
    output logic [cpu_pkg::xlen-1:0] imm
);

    cpu_pkg::opcode_e opcode;

    assign opcode = cpu_pkg::opcode_e'(instr[cpu_pkg::opcode_lsb +: cpu_pkg::opcode_w]);

    always_comb begin
        case (opcode)
            // I-type
            cpu_pkg::opc_op_imm, cpu_pkg::opc_load, cpu_pkg::opc_jalr: begin
                imm = {{20{instr[31]}}, instr[31:20]};
            end
            // S-type
            cpu_pkg::opc_store: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            // B-type with bit 0 implied zero
            cpu_pkg::opc_branch: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            cpu_pkg::opc_lui, cpu_pkg::opc_auipc: begin
                imm = {instr[31:12], 12'b0};
            end
            // J-type
            cpu_pkg::opc_jal: begin
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr0,
    input  logic [cpu_pkg::reg_addr_w-1:0] raddr1,
    input  logic                          we,
    input  logic [cpu_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_pkg::xlen-1:0]       wdata,
    output logic [cpu_pkg::xlen-1:0]       rdata0,
    output logic [cpu_pkg::xlen-1:0]       rdata1
);

    localparam int num_regs = 2 ** cpu_pkg::reg_addr_w;

    logic [cpu_pkg::xlen-1:0] regs [num_regs];

    // x0 is never written, so it stays at its reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational read ports
    assign rdata0 = regs[raddr0];
    assign rdata1 = regs[raddr1];

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [cpu_pkg::xlen-1:0] src0,
    input  logic [cpu_pkg::xlen-1:0] src1,
    input  cpu_pkg::alu_op_e         alu_op,
    output logic [cpu_pkg::xlen-1:0] result,
    output logic                     zero
);

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_add: result = src0 + src1;
            cpu_pkg::alu_sub: result = src0 - src1;
            cpu_pkg::alu_and: result = src0 & src1;
            cpu_pkg::alu_or:  result = src0 | src1;
            default:          result = src0 + src1;
        endcase
    end

    // BEQ compares through SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
    input  logic                     clk,
    input  logic                     rst_n,
    input  cpu_pkg::pc_sel_e         pc_sel,
    input  logic                     zero,
    input  logic [cpu_pkg::xlen-1:0] imm,
    input  logic [cpu_pkg::xlen-1:0] alu_result,
    output logic [cpu_pkg::xlen-1:0] pc
);

    logic [cpu_pkg::xlen-1:0] pc4;
    logic [cpu_pkg::xlen-1:0] pcimm;
    logic [cpu_pkg::xlen-1:0] pc_next;

    assign pc4   = pc + 32'd4;
    assign pcimm = pc + imm;

    always_comb begin
        case (pc_sel)
            cpu_pkg::pc_seq:  pc_next = pc4;
            cpu_pkg::pc_beq:  pc_next = zero ? pcimm : pc4;
            cpu_pkg::pc_jal:  pc_next = pcimm;
            // JALR clears bit 0 of the target
            cpu_pkg::pc_jalr: pc_next = {alu_result[cpu_pkg::xlen-1:1], 1'b0};
            default:          pc_next = pc4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  logic                     clk,
    input  logic                     rst_n,
    // Instruction memory
    output logic [cpu_pkg::xlen-1:0] imem_addr,
    input  logic [cpu_pkg::xlen-1:0] imem_rdata,
    // Data memory
    output logic [cpu_pkg::xlen-1:0] dmem_addr,
    output logic [cpu_pkg::xlen-1:0] dmem_wdata,
    output logic                     dmem_we,
    input  logic [cpu_pkg::xlen-1:0] dmem_rdata
);

    logic [cpu_pkg::xlen-1:0]       pc;
    logic [cpu_pkg::xlen-1:0]       imm;
    logic [cpu_pkg::reg_addr_w-1:0] rs1;
    logic [cpu_pkg::reg_addr_w-1:0] rs2;
    logic [cpu_pkg::reg_addr_w-1:0] rd;
    logic [cpu_pkg::xlen-1:0]       rdata0;
    logic [cpu_pkg::xlen-1:0]       rdata1;
    logic [cpu_pkg::xlen-1:0]       src0;
    logic [cpu_pkg::xlen-1:0]       src1;
    logic [cpu_pkg::xlen-1:0]       alu_result;
    logic                           alu_zero;
    logic [cpu_pkg::xlen-1:0]       pc4;
    logic [cpu_pkg::xlen-1:0]       pcimm;
    logic [cpu_pkg::xlen-1:0]       reg_wdata;

    ctrl_if ctrl_bus ();

    ////////////////////////////////////////////////////////////
    // Fetch and decode
    ////////////////////////////////////////////////////////////
    assign imem_addr = pc;

    assign rs1 = imem_rdata[cpu_pkg::rs1_lsb +: cpu_pkg::reg_addr_w];
    assign rs2 = imem_rdata[cpu_pkg::rs2_lsb +: cpu_pkg::reg_addr_w];
    assign rd  = imem_rdata[cpu_pkg::rd_lsb +: cpu_pkg::reg_addr_w];

    control_unit u_control (
        .instr (imem_rdata),
        .ctrl  (ctrl_bus)
    );

    imm_gen u_imm_gen (
        .instr (imem_rdata),
        .imm   (imm)
    );

    register_file u_register_file (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr0 (rs1),
        .raddr1 (rs2),
        .we     (ctrl_bus.reg_we),
        .waddr  (rd),
        .wdata  (reg_wdata),
        .rdata0 (rdata0),
        .rdata1 (rdata1)
    );

    ////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////
    // Zero operand serves LUI
    assign src0 = ctrl_bus.src0_zero ? '0 : rdata0;
    assign src1 = ctrl_bus.src1_imm ? imm : rdata1;

    alu u_alu (
        .src0   (src0),
        .src1   (src1),
        .alu_op (ctrl_bus.alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

    pc_unit u_pc_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .pc_sel     (ctrl_bus.pc_sel),
        .zero       (alu_zero),
        .imm        (imm),
        .alu_result (alu_result),
        .pc         (pc)
    );

    // Store address comes from the ALU, store data from rs2
    assign dmem_addr  = alu_result;
    assign dmem_wdata = rdata1;
    assign dmem_we    = ctrl_bus.mem_we;

    ////////////////////////////////////////////////////////////
    // Write-back
    ////////////////////////////////////////////////////////////
    assign pc4   = pc + 32'd4;
    assign pcimm = pc + imm;

    always_comb begin
        case (ctrl_bus.wb_sel)
            cpu_pkg::wb_alu:   reg_wdata = alu_result;
            cpu_pkg::wb_mem:   reg_wdata = dmem_rdata;
            cpu_pkg::wb_pc4:   reg_wdata = pc4;
            cpu_pkg::wb_pcimm: reg_wdata = pcimm;
            default:           reg_wdata = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 4 ns period
    always begin
        #2 clk = ~clk;
    end

endmodule

`default_nettype wire

// File: testbench/cpu_assert.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_assert (
    input logic                     clk,
    input logic                     rst_n,
    input logic [cpu_pkg::xlen-1:0] imem_addr,
    input logic                     dmem_we
);

    pc_aligned: assert property (
        @(posedge clk) disable iff (!rst_n) imem_addr[1:0] == 2'b00
    ) else $error("PC 0x%08h is not word aligned", imem_addr);

    we_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(dmem_we)
    ) else $error("dmem_we is unknown");

    // First cycle out of reset fetches from address 0
    pc_starts_at_zero: assert property (
        @(posedge clk) $rose(rst_n) |-> imem_addr == '0
    ) else $error("PC 0x%08h after reset release, expected 0", imem_addr);

endmodule

`default_nettype wire

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

    logic        clk;
    logic        rst_n;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_we;
    logic [31:0] dmem_rdata;

    // 256 words or 1 KB each
    logic [31:0] imem [256];
    logic [31:0] dmem [256];

    logic [31:0] store_addr [$];
    logic [31:0] store_data [$];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] pc_trace [$];
    logic [31:0] exp_trace [$];
    int          log_base;
    int          prog_pc;
    int          errors;

    tb_clock clk_gen_i (.clk(clk));

    cpu_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    bind cpu_top cpu_assert cpu_assert_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .dmem_we   (dmem_we)
    );

    ////////////////////////////////////////////////////////////
    // Memory models
    ////////////////////////////////////////////////////////////
    // NOP during reset and beyond the end of the array
    assign imem_rdata = (!rst_n || imem_addr >= 32'd1024) ? cpu_pkg::nop_instr
                                                          : imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    // Store log, taken at the rising edge
    always @(posedge clk) begin
        if (rst_n && dmem_we) begin
            store_addr.push_back(dmem_addr);
            store_data.push_back(dmem_wdata);
        end
    end

    ////////////////////////////////////////////////////////////
    // RV32I encoders
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] imm_op(input logic [2:0] f3, input int rd,
                                           input int rs1, input int imm);
        return {12'(imm), 5'(rs1), f3, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] load_word(input int rd, input int rs1, input int off);
        return {12'(off), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(input int rs2, input int rs1, input int off);
        logic [11:0] s;
        s = 12'(off);
        return {s[11:5], 5'(rs2), 5'(rs1), 3'b010, s[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_eq(input int rs1, input int rs2, input int off);
        logic [12:0] b;
        b = 13'(off);
        return {b[12], b[10:5], 5'(rs2), 5'(rs1), 3'b000, b[4:1], b[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jump_link(input int rd, input int off);
        logic [20:0] j;
        j = 21'(off);
        return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'b1101111};
    endfunction

    function automatic logic [31:0] jump_reg(input int rd, input int rs1, input int imm);
        return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b1100111};
    endfunction

    // LUI, or AUIPC when is_auipc is set
    function automatic logic [31:0] upper_imm(input logic is_auipc, input int rd,
                                              input int upper);
        return {20'(upper), 5'(rd), is_auipc ? 7'b0010111 : 7'b0110111};
    endfunction

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string why);
        errors++;
        $display("SIMULATION FAILED");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at time %0t: %s expected 0x%08h, got 0x%08h",
                     $time, name, exp, got);
            abort_run("value mismatch");
        end
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) begin
            imem[8'(i)] = cpu_pkg::nop_instr;
            dmem[8'(i)] = 32'hd000_0000 | (i * 4);
        end
        prog_pc = 0;
        exp_addr.delete();
        exp_data.delete();
        pc_trace.delete();
        exp_trace.delete();
    endtask

    task automatic emit(input logic [31:0] instr);
        imem[8'(prog_pc / 4)] = instr;
        prog_pc += 4;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    // Memories are loaded while reset is held
    task automatic hold_reset();
        @(negedge clk);
        rst_n = 1'b0;
        clear_memories();
    endtask

    task automatic run_until(input logic [31:0] end_addr, input int limit);
        int cycles;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        log_base = store_addr.size();
        cycles = 0;
        while (imem_addr !== end_addr) begin
            pc_trace.push_back(imem_addr);
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                $display("ERROR: PC did not reach 0x%08h within %0d cycles", end_addr, limit);
                abort_run("timeout");
            end
        end
    endtask

    task automatic compare_stores();
        int n;
        n = store_addr.size() - log_base;
        check_value("store count", 32'(n), 32'(exp_addr.size()));
        for (int i = 0; i < n; i++) begin
            check_value($sformatf("dmem_addr of store %0d", i), store_addr[log_base + i],
                        exp_addr[i]);
            check_value($sformatf("dmem_wdata of store %0d", i), store_data[log_base + i],
                        exp_data[i]);
        end
    endtask

    task automatic confirm_trace();
        check_value("fetch count", 32'(pc_trace.size()), 32'(exp_trace.size()));
        for (int i = 0; i < pc_trace.size(); i++) begin
            check_value($sformatf("imem_addr at step %0d", i), pc_trace[i], exp_trace[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic arith_logic_test();
        logic [31:0] a;
        logic [31:0] b;
        a = 32'h0000_05a3;
        b = 32'hffff_fedd;
        hold_reset();
        emit(imm_op(3'b000, 1, 0, 'h5a3));
        emit(imm_op(3'b000, 2, 0, -291));
        emit(reg_op(7'b0000000, 3'b000, 3, 1, 2));
        emit(reg_op(7'b0100000, 3'b000, 4, 1, 2));
        emit(reg_op(7'b0000000, 3'b111, 5, 1, 2));
        emit(reg_op(7'b0000000, 3'b110, 6, 1, 2));
        emit(imm_op(3'b111, 7, 1, 'h0f0));
        emit(imm_op(3'b110, 8, 2, 'h123));
        for (int r = 3; r <= 8; r++) begin
            emit(store_word(r, 0, 4 * (r - 3)));
        end
        expect_store(32'h00, a + b);
        expect_store(32'h04, a - b);
        expect_store(32'h08, a & b);
        expect_store(32'h0c, a | b);
        expect_store(32'h10, a & 32'h0000_00f0);
        expect_store(32'h14, b | 32'h0000_0123);
        run_until(prog_pc, prog_pc / 4 + 16);
        compare_stores();
    endtask

    task automatic load_add_store_test();
        hold_reset();
        dmem[8'h10] = 32'h8765_4321;
        dmem[8'h11] = 32'h9abc_def0;
        emit(load_word(1, 0, 'h40));
        emit(load_word(2, 0, 'h44));
        emit(reg_op(7'b0000000, 3'b000, 3, 1, 2));
        emit(store_word(3, 0, 'h48));
        expect_store(32'h48, 32'h8765_4321 + 32'h9abc_def0);
        run_until(prog_pc, prog_pc / 4 + 16);
        compare_stores();
    endtask

    task automatic branch_test();
        hold_reset();
        emit(imm_op(3'b000, 1, 0, 7));
        emit(imm_op(3'b000, 2, 0, 7));
        emit(imm_op(3'b000, 3, 0, 9));
        emit(branch_eq(1, 2, 12));
        emit(store_word(1, 0, 'h10));
        emit(store_word(1, 0, 'h14));
        emit(branch_eq(1, 3, 12));
        emit(store_word(3, 0, 'h18));
        emit(store_word(2, 0, 'h1c));
        // Taken at 12 lands on 24, not taken at 24 falls through
        exp_trace = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd24, 32'd28, 32'd32};
        expect_store(32'h18, 32'd9);
        expect_store(32'h1c, 32'd7);
        run_until(prog_pc, prog_pc / 4 + 16);
        confirm_trace();
        compare_stores();
    endtask

    task automatic jump_link_test();
        hold_reset();
        emit(jump_link(1, 12));
        emit(store_word(1, 0, 'h20));
        emit(store_word(1, 0, 'h24));
        emit(store_word(1, 0, 'h28));
        emit(imm_op(3'b000, 5, 0, 30));
        // 30 + 3 is odd, bit 0 cleared gives 32
        emit(jump_reg(2, 5, 3));
        emit(store_word(2, 0, 'h2c));
        emit(store_word(2, 0, 'h30));
        emit(store_word(2, 0, 'h34));
        exp_trace = '{32'd0, 32'd12, 32'd16, 32'd20, 32'd32};
        expect_store(32'h28, 32'd0 + 32'd4);
        expect_store(32'h34, 32'd20 + 32'd4);
        run_until(prog_pc, prog_pc / 4 + 16);
        confirm_trace();
        compare_stores();
    endtask

    task automatic upper_imm_test();
        hold_reset();
        emit(upper_imm(1'b0, 1, 'habcde));
        emit(store_word(1, 0, 'h40));
        emit(upper_imm(1'b1, 2, 'h12345));
        emit(store_word(2, 0, 'h44));
        emit(imm_op(3'b000, 0, 0, 'h55));
        emit(store_word(0, 0, 'h48));
        emit(imm_op(3'b000, 3, 0, 'h77));
        // custom-0 opcode with rd = x3
        emit({7'b0000000, 5'd3, 5'd3, 3'b000, 5'd3, 7'b0001011});
        emit(store_word(3, 0, 'h4c));
        for (int i = 0; i < prog_pc; i += 4) begin
            exp_trace.push_back(32'(i));
        end
        expect_store(32'h40, 32'habcd_e000);
        expect_store(32'h44, 32'h1234_5000 + 32'd8);
        expect_store(32'h48, 32'h0);
        expect_store(32'h4c, 32'h77);
        run_until(prog_pc, prog_pc / 4 + 16);
        confirm_trace();
        compare_stores();
    endtask

    task automatic random_add_sub_test();
        logic [31:0] a;
        logic [31:0] b;
        hold_reset();
        for (int i = 0; i < 20; i++) begin
            a = $urandom();
            b = $urandom();
            dmem[8'(2 * i)] = a;
            dmem[8'(2 * i + 1)] = b;
            emit(load_word(1, 0, 8 * i));
            emit(load_word(2, 0, 8 * i + 4));
            emit(reg_op(7'b0000000, 3'b000, 3, 1, 2));
            emit(reg_op(7'b0100000, 3'b000, 4, 1, 2));
            emit(store_word(3, 0, 'h200 + 8 * i));
            emit(store_word(4, 0, 'h204 + 8 * i));
            expect_store(32'h200 + 8 * i, a + b);
            expect_store(32'h204 + 8 * i, a - b);
        end
        run_until(prog_pc, prog_pc / 4 + 16);
        compare_stores();
    endtask

    initial begin
        errors = 0;
        log_base = 0;
        rst_n = 1'b0;
        void'($urandom(25068));
        clear_memories();
        arith_logic_test();
        load_add_store_test();
        branch_test();
        jump_link_test();
        upper_imm_test();
        random_add_sub_test();
        if (errors == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            abort_run("one or more checks failed");
        end
    end

endmodule

`default_nettype wire

// File: src.f
hdl/cpu_pkg.sv
hdl/ctrl_if.sv
hdl/control_unit.sv
hdl/imm_gen.sv
hdl/register_file.sv
hdl/alu.sv
hdl/pc_unit.sv
hdl/cpu_top.sv
testbench/tb_clock.sv
testbench/cpu_assert.sv
testbench/cpu_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module cpu_tb -f src.f -o cpu_sim

status=0
./obj_dir/cpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^SIMULATION PASSED$" sim.log; then
    exit 0
fi
echo "simulation exit status: $status"
exit 1
